//--- flist.f
+incdir+.
mux_pkg.sv
group_extract.sv
fetch_history.sv
mux_stage_reg.sv
flow_detect.sv
pipeline_mux.sv
tb_pipeline_mux.sv

//--- Bender.yml
package:
  name: pipeline_mux

sources:
  - include_dirs:
      - .
    files:
      - mux_pkg.sv
      - group_extract.sv
      - fetch_history.sv
      - mux_stage_reg.sv
      - flow_detect.sv
      - pipeline_mux.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pipeline_mux.sv

//--- tb_mux_model.svh
// ====================
// Reference model for the mux stage testbench
// Line window, slot rules and first-flow scan
// ====================

`ifndef TB_MUX_MODEL_SVH
`define TB_MUX_MODEL_SVH

// Parcel at a line index; anything past the last parcel reads as NOP
function automatic logic [`MUX_PARCEL_BITS-1:0] parcel_at(
	input logic [`MUX_LINE_BITS-1:0] line, input int idx);
	if (idx < `MUX_LINE_BITS / `MUX_PARCEL_BITS)
		return line[idx*`MUX_PARCEL_BITS +: `MUX_PARCEL_BITS];
	return `MUX_PARCEL_BITS'(mux_pkg::OP_NOP);
endfunction

// Parcel index of the PC on the line
function automatic int parcel_index(input mux_pkg::pc_t pc);
	return int'((pc >> 1) % (`MUX_LINE_BITS / `MUX_PARCEL_BITS));
endfunction

// Twelve parcels starting at the PC's parcel
function automatic logic [`MUX_WIN_BITS-1:0] window_of(
	input logic [`MUX_LINE_BITS-1:0] line, input mux_pkg::pc_t pc);
	logic [`MUX_WIN_BITS-1:0] win;
	for (int p = 0; p < `MUX_SLOTS * `MUX_SLOT_STRIDE; p++)
		win[p*`MUX_PARCEL_BITS +: `MUX_PARCEL_BITS] = parcel_at(line, parcel_index(pc) + p);
	return win;
endfunction

// Expected group from one set of stage inputs
function automatic mux_pkg::slot_t [`MUX_SLOTS-1:0] build_group(
	input logic [`MUX_LINE_BITS-1:0] line, input mux_pkg::pc_t pc,
	input logic ssm, input logic ssm_prev, input logic irq, input logic stomp,
	input logic bm, input mux_pkg::pc_t misspc, input logic redundant);
	mux_pkg::slot_t [`MUX_SLOTS-1:0] g;
	logic [`MUX_WIN_BITS-1:0] win;
	logic stepped;
	win = window_of(line, pc);
	for (int k = 0; k < `MUX_SLOTS; k++) begin
		g[k].pc = pc + mux_pkg::pc_t'(k * (`MUX_INS_BITS / 8));
		g[k].cli = `MUX_CLI_BITS'(parcel_index(pc) + k * `MUX_SLOT_STRIDE);
		g[k].ins = redundant ? mux_pkg::NOP_INS : win[k*`MUX_INS_BITS +: `MUX_INS_BITS];
		// Only slot 0 on the first step cycle escapes the step NOP
		stepped = ssm && (k > 0 || ssm_prev);
		g[k].ssm = stepped;
		if (stepped)
			g[k].ins = mux_pkg::NOP_INS;
		g[k].valid = !(irq || stomp || stepped);
		if (bm && misspc > g[k].pc) begin
			g[k].ins = mux_pkg::NOP_INS;
			g[k].valid = 1'b0;
		end
	end
	return g;
endfunction

// First valid call, branch or return decides the flow outputs
task automatic flow_model(input mux_pkg::slot_t [`MUX_SLOTS-1:0] g,
	output logic bsr, output logic call, output logic ret,
	output mux_pkg::pc_t tgt, output mux_pkg::pc_t rpc);
	logic done;
	logic [6:0] op;
	mux_pkg::pc_t rel;
	bsr = 1'b0;
	call = 1'b0;
	ret = 1'b0;
	tgt = `MUX_RESET_PC;
	rpc = `MUX_RESET_PC;
	done = 1'b0;
	for (int k = 0; k < `MUX_SLOTS; k++) begin
		op = g[k].ins[6:0];
		rel = g[k].pc + {{8{g[k].ins[47]}}, g[k].ins[47:24]};
		if (!done && g[k].valid) begin
			if (op == mux_pkg::OP_BSR || op == mux_pkg::OP_JSR || op == mux_pkg::OP_BCC) begin
				done = 1'b1;
				bsr = 1'b1;
				tgt = (op == mux_pkg::OP_JSR) ? g[k].ins[47:16] : rel;
				if (op != mux_pkg::OP_BCC) begin
					call = 1'b1;
					rpc = g[k].pc + mux_pkg::pc_t'(`MUX_INS_BITS / 8);
				end
			end else if (op == mux_pkg::OP_RET) begin
				done = 1'b1;
				ret = 1'b1;
			end
		end
	end
endtask

`endif

//--- tb_pipeline_mux.sv
// ====================
// Testbench for the instruction-group mux stage
// Seeded random groups checked against a model
// ====================

`timescale 1ns/1ns

`include "mux_settings.svh"

module tb_pipeline_mux;

	logic clk, rst_i, en_i, mux_stall_i, advance_fet_i;
	logic [`MUX_LINE_BITS-1:0] line_i;
	mux_pkg::pc_t pc_i, misspc_i, bsr_tgt_o, ret_pc_o;
	logic ssm_i, irq_i, stomp_i, flush_i, branchmiss_i;
	mux_pkg::irq_hdr_t irq_hdr_i, irq_hdr_o;
	mux_pkg::slot_t slot_o [`MUX_SLOTS];
	logic nop_o, flush_o, new_cline_o, do_bsr_o, do_call_o, do_ret_o;

	// Model history as of the last advance and model stage as of the last enabled edge
	mux_pkg::pc_t m_pc;
	logic [`MUX_WIN_BITS-1:0] m_win;
	logic [`MUX_LINE_BITS-1:0] m_line_q, m_line_qq;
	logic m_ssm_q;
	mux_pkg::slot_t [`MUX_SLOTS-1:0] exp_slot;
	mux_pkg::irq_hdr_t exp_hdr;
	logic exp_nop, exp_flush;
	int err_count, test_err, tests_run, tests_failed;

	`include "tb_mux_model.svh"

	pipeline_mux u_dut (.*);

	always #20 clk = ~clk;

	// ====================
	// Checks and bookkeeping
	// ====================

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		if (exp !== act) begin
			$display("Mismatch %s expected %h actual %h", name, exp, act);
			err_count++;
			test_err++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_err == 0) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s failed with %0d errors", name, test_err);
			tests_failed++;
		end
		test_err = 0;
	endtask

	// ====================
	// Random stimulus
	// ====================

	function automatic logic [6:0] rand_opcode();
		case ($urandom % 6)
			0: return mux_pkg::OP_NOP;
			1: return mux_pkg::OP_ALU;
			2: return mux_pkg::OP_BSR;
			3: return mux_pkg::OP_JSR;
			4: return mux_pkg::OP_RET;
			default: return mux_pkg::OP_BCC;
		endcase
	endfunction

	// Line of whole instructions at every third parcel, the last one cut off
	function automatic logic [`MUX_LINE_BITS-1:0] rand_line();
		logic [`MUX_LINE_BITS+`MUX_INS_BITS-1:0] wide;
		mux_pkg::ins_t ins;
		wide = '0;
		for (int i = 0; i * `MUX_SLOT_STRIDE < `MUX_LINE_BITS / `MUX_PARCEL_BITS; i++) begin
			ins = mux_pkg::ins_t'({$urandom, $urandom});
			ins[6:0] = rand_opcode();
			wide[i*`MUX_INS_BITS +: `MUX_INS_BITS] = ins;
		end
		return wide[`MUX_LINE_BITS-1:0];
	endfunction

	// Load a fresh group; an aligned PC lands on an instruction boundary
	task automatic new_group(input logic aligned);
		line_i = rand_line();
		pc_i = $urandom;
		if (aligned) begin
			pc_i[5:1] = 5'(3 * ($urandom % 11));
			pc_i[0] = 1'b0;
		end
	endtask

	task automatic quiet_controls();
		en_i = 1'b1;
		mux_stall_i = 1'b0;
		advance_fet_i = 1'b1;
		{ssm_i, irq_i, stomp_i, flush_i, branchmiss_i} = '0;
		misspc_i = '0;
		irq_hdr_i = '0;
	endtask

	// One clock with model update and full output check
	// Entered and left 2 ns after a rising edge
	task automatic apply_cycle(input string name);
		mux_pkg::slot_t [`MUX_SLOTS-1:0] grp;
		logic red, e_bsr, e_call, e_ret;
		mux_pkg::pc_t e_tgt, e_rpc;
		red = (m_pc == pc_i) && (m_win == window_of(line_i, pc_i));
		grp = build_group(line_i, pc_i, ssm_i, m_ssm_q, irq_i, stomp_i,
			branchmiss_i, misspc_i, red);
		@(posedge clk);
		if (en_i && !mux_stall_i) begin
			exp_slot = grp;
			exp_hdr = irq_hdr_i;
			exp_nop = stomp_i;
			exp_flush = flush_i;
			m_ssm_q = ssm_i;
		end
		if (advance_fet_i) begin
			m_pc = pc_i;
			m_win = window_of(line_i, pc_i);
			m_line_qq = m_line_q;
			m_line_q = line_i;
		end
		#1;
		flow_model(exp_slot, e_bsr, e_call, e_ret, e_tgt, e_rpc);
		for (int k = 0; k < `MUX_SLOTS; k++)
			check_value($sformatf("%s slot%0d", name, k), exp_slot[k], slot_o[k]);
		check_value({name, " irq_hdr"}, exp_hdr, irq_hdr_o);
		check_value({name, " nop"}, exp_nop, nop_o);
		check_value({name, " flush"}, exp_flush, flush_o);
		check_value({name, " new_cline"}, m_line_q != m_line_qq, new_cline_o);
		check_value({name, " do_bsr"}, e_bsr, do_bsr_o);
		check_value({name, " do_call"}, e_call, do_call_o);
		check_value({name, " do_ret"}, e_ret, do_ret_o);
		check_value({name, " bsr_tgt"}, e_tgt, bsr_tgt_o);
		check_value({name, " ret_pc"}, e_rpc, ret_pc_o);
		#1;
	endtask

	// Reset for eight cycles, then check the idle outputs
	task automatic do_reset();
		int n;
		rst_i = 1'b1;
		n = 0;
		while (n < 8) begin
			@(posedge clk);
			n++;
		end
		#2 rst_i = 1'b0;
		@(posedge clk);
		#1;
		for (int k = 0; k < `MUX_SLOTS; k++)
			check_value($sformatf("reset valid%0d", k), 1'b0, slot_o[k].valid);
		check_value("reset nop", 1'b0, nop_o);
		check_value("reset flush", 1'b0, flush_o);
		check_value("reset hwi", 1'b0, irq_hdr_o.hwi);
		check_value("reset new_cline", 1'b0, new_cline_o);
		check_value("reset do_flags", 3'b000, {do_bsr_o, do_call_o, do_ret_o});
		check_value("reset bsr_tgt", `MUX_RESET_PC, bsr_tgt_o);
		check_value("reset ret_pc", `MUX_RESET_PC, ret_pc_o);
		#1;
	endtask

	// Poll for the new-line flag, with the stage idle after the loading advance
	task automatic wait_new_cline(input string name);
		int n;
		n = 0;
		apply_cycle(name);
		advance_fet_i = 1'b0;
		en_i = 1'b0;
		while (!new_cline_o && n < 4) begin
			apply_cycle(name);
			n++;
		end
		if (!new_cline_o) begin
			$display("Test %s: new_cline_o did not rise within 4 cycles", name);
			err_count++;
			test_err++;
		end
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		mux_pkg::slot_t [`MUX_SLOTS-1:0] held;
		void'($urandom(32'hb3733f94));
		clk = 1'b0;
		rst_i = 1'b1;
		quiet_controls();
		en_i = 1'b0;
		advance_fet_i = 1'b0;
		line_i = '0;
		pc_i = '0;
		{m_pc, m_win, m_line_q, m_line_qq, m_ssm_q} = '0;
		{exp_slot, exp_hdr, exp_nop, exp_flush} = '0;
		{err_count, test_err, tests_run, tests_failed} = '0;

		do_reset();
		end_test("reset");

		quiet_controls();
		repeat (20) begin
			new_group(1'b0);
			apply_cycle("align");
		end
		end_test("align");

		for (int i = 0; i < 12; i++) begin
			new_group(1'b0);
			irq_i = (i % 3 == 0);
			stomp_i = (i % 3 == 1);
			flush_i = $urandom;
			irq_hdr_i = mux_pkg::irq_hdr_t'($urandom);
			irq_hdr_i.hwi = irq_i;
			apply_cycle("invalidate");
		end
		quiet_controls();
		// Miss PC lands somewhere across the four slot PCs
		for (int i = 0; i < 12; i++) begin
			new_group(1'b1);
			branchmiss_i = 1'b1;
			misspc_i = pc_i + ($urandom % 26);
			apply_cycle("invalidate");
		end
		end_test("invalidate");

		quiet_controls();
		for (int i = 0; i < 6; i++) begin
			// The third step cycle repeats the previous fetch
			if (i != 2)
				new_group(1'b1);
			ssm_i = (i < 4);
			apply_cycle("single_step");
		end
		end_test("single_step");

		quiet_controls();
		new_group(1'b1);
		apply_cycle("history");
		apply_cycle("history");
		line_i = rand_line();
		wait_new_cline("history");
		end_test("history");

		quiet_controls();
		repeat (30) begin
			new_group(1'b1);
			apply_cycle("flow");
		end
		end_test("flow");

		new_group(1'b1);
		apply_cycle("stall");
		held = exp_slot;
		mux_stall_i = 1'b1;
		advance_fet_i = 1'b0;
		for (int i = 0; i < 4; i++) begin
			new_group(1'b1);
			irq_i = $urandom;
			apply_cycle("stall");
			for (int k = 0; k < `MUX_SLOTS; k++)
				check_value($sformatf("stall hold%0d", k), held[k], slot_o[k]);
		end
		mux_stall_i = 1'b0;
		end_test("stall");

		$display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- pipeline_mux.sv
// ====================
// Instruction-group mux stage, top level
// Extract and history side by side, then stage register and flow detect
// ====================

`timescale 1ns/1ns

`include "mux_settings.svh"

module pipeline_mux (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      en_i,
	input  logic                      mux_stall_i,
	input  logic                      advance_fet_i,
	input  logic [`MUX_LINE_BITS-1:0] line_i,
	input  mux_pkg::pc_t              pc_i,
	input  logic                      ssm_i,
	input  logic                      irq_i,
	input  logic                      stomp_i,
	input  logic                      flush_i,
	input  logic                      branchmiss_i,
	input  mux_pkg::pc_t              misspc_i,
	input  mux_pkg::irq_hdr_t         irq_hdr_i,
	output mux_pkg::slot_t            slot_o [`MUX_SLOTS],
	output mux_pkg::irq_hdr_t         irq_hdr_o,
	output logic                      nop_o,
	output logic                      flush_o,
	output logic                      new_cline_o,
	output logic                      do_bsr_o,
	output logic                      do_call_o,
	output logic                      do_ret_o,
	output mux_pkg::pc_t              bsr_tgt_o,
	output mux_pkg::pc_t              ret_pc_o
);

	mux_pkg::ins_t raw_ins [`MUX_SLOTS];
	mux_pkg::pc_t slot_pc [`MUX_SLOTS];
	logic [`MUX_CLI_BITS-1:0] cli [`MUX_SLOTS];
	logic [`MUX_WIN_BITS-1:0] aligned;
	logic redundant;
	logic stage_en;

	// Back-pressure freezes the stage register
	assign stage_en = en_i & ~mux_stall_i;

	group_extract u_extract (
		.line_i    (line_i),
		.pc_i      (pc_i),
		.raw_ins_o (raw_ins),
		.slot_pc_o (slot_pc),
		.cli_o     (cli),
		.aligned_o (aligned)
	);

	// History runs on the fetch advance, not on the stage enable
	fetch_history u_history (
		.clk         (clk),
		.rst_i       (rst_i),
		.advance_i   (advance_fet_i),
		.pc_i        (pc_i),
		.aligned_i   (aligned),
		.line_i      (line_i),
		.redundant_o (redundant),
		.new_cline_o (new_cline_o)
	);

	mux_stage_reg u_stage (
		.clk          (clk),
		.rst_i        (rst_i),
		.stage_en_i   (stage_en),
		.raw_ins_i    (raw_ins),
		.slot_pc_i    (slot_pc),
		.cli_i        (cli),
		.redundant_i  (redundant),
		.ssm_i        (ssm_i),
		.irq_i        (irq_i),
		.stomp_i      (stomp_i),
		.flush_i      (flush_i),
		.branchmiss_i (branchmiss_i),
		.misspc_i     (misspc_i),
		.irq_hdr_i    (irq_hdr_i),
		.slot_o       (slot_o),
		.irq_hdr_o    (irq_hdr_o),
		.nop_o        (nop_o),
		.flush_o      (flush_o)
	);

	flow_detect u_flow (
		.slot_i    (slot_o),
		.do_bsr_o  (do_bsr_o),
		.do_call_o (do_call_o),
		.do_ret_o  (do_ret_o),
		.bsr_tgt_o (bsr_tgt_o),
		.ret_pc_o  (ret_pc_o)
	);

	// A group resolves to a branch or a return, never both
	a_bsr_ret_excl: assert property (@(posedge clk) disable iff (rst_i)
		!(do_bsr_o && do_ret_o))
		else $error("do_bsr and do_ret high together");

	// Calls are a subset of the branch class
	a_call_is_bsr: assert property (@(posedge clk) disable iff (rst_i)
		do_call_o |-> do_bsr_o)
		else $error("do_call without do_bsr");

endmodule

//--- flow_detect.sv
// ====================
// Flow-change detector
// Finds the first call, branch or return in the registered group
// and forms its target and return PC
// ====================

`timescale 1ns/1ns

`include "mux_settings.svh"

module flow_detect (
	input  mux_pkg::slot_t slot_i [`MUX_SLOTS],
	output logic           do_bsr_o,
	output logic           do_call_o,
	output logic           do_ret_o,
	output mux_pkg::pc_t   bsr_tgt_o,
	output mux_pkg::pc_t   ret_pc_o
);

	// Displacement and absolute target fields of the instruction
	localparam int DISP_LSB = 24;
	localparam int DISP_BITS = `MUX_INS_BITS - DISP_LSB;
	localparam int ABS_LSB = 16;

	// Byte length of one instruction, used for the link address
	localparam int INS_BYTES = `MUX_INS_BITS / 8;

	mux_pkg::opcode_e opc [`MUX_SLOTS];
	mux_pkg::pc_t rel_tgt [`MUX_SLOTS];
	mux_pkg::pc_t abs_tgt [`MUX_SLOTS];
	mux_pkg::pc_t link_pc [`MUX_SLOTS];
	logic [DISP_BITS-1:0] disp [`MUX_SLOTS];
	logic found;

	// ====================
	// Per-slot decode
	// ====================

	always_comb begin
		for (int k = 0; k < `MUX_SLOTS; k++) begin
			opc[k] = mux_pkg::opcode_e'(slot_i[k].ins[6:0]);
			disp[k] = slot_i[k].ins[`MUX_INS_BITS-1:DISP_LSB];
			// PC relative target with sign-extended displacement
			rel_tgt[k] = slot_i[k].pc +
				{{(`MUX_PC_BITS - DISP_BITS){disp[k][DISP_BITS-1]}}, disp[k]};
			abs_tgt[k] = slot_i[k].ins[ABS_LSB +: `MUX_PC_BITS];
			link_pc[k] = slot_i[k].pc + `MUX_PC_BITS'(INS_BYTES);
		end
	end

	// ====================
	// Priority scan
	// ====================

	// Slot 0 has priority and only the first flow instruction counts
	always_comb begin
		found = 1'b0;
		do_bsr_o = 1'b0;
		do_call_o = 1'b0;
		do_ret_o = 1'b0;
		bsr_tgt_o = `MUX_RESET_PC;
		ret_pc_o = `MUX_RESET_PC;
		for (int k = 0; k < `MUX_SLOTS; k++) begin
			if (!found && slot_i[k].valid) begin
				case (opc[k])
					mux_pkg::OP_BSR: begin
						found = 1'b1;
						do_bsr_o = 1'b1;
						do_call_o = 1'b1;
						bsr_tgt_o = rel_tgt[k];
						ret_pc_o = link_pc[k];
					end
					mux_pkg::OP_JSR: begin
						found = 1'b1;
						do_bsr_o = 1'b1;
						do_call_o = 1'b1;
						bsr_tgt_o = abs_tgt[k];
						ret_pc_o = link_pc[k];
					end
					mux_pkg::OP_BCC: begin
						found = 1'b1;
						do_bsr_o = 1'b1;
						bsr_tgt_o = rel_tgt[k];
					end
					mux_pkg::OP_RET: begin
						found = 1'b1;
						do_ret_o = 1'b1;
					end
					default: begin
						found = 1'b0;
					end
				endcase
			end
		end
	end

endmodule

//--- mux_stage_reg.sv
// ====================
// Mux stage register
// Applies single-step, interrupt, stomp and branch-miss rules
// and captures the group with its interrupt header
// ====================

`timescale 1ns/1ns

`include "mux_settings.svh"

module mux_stage_reg (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     stage_en_i,
	input  mux_pkg::ins_t            raw_ins_i [`MUX_SLOTS],
	input  mux_pkg::pc_t             slot_pc_i [`MUX_SLOTS],
	input  logic [`MUX_CLI_BITS-1:0] cli_i [`MUX_SLOTS],
	input  logic                     redundant_i,
	input  logic                     ssm_i,
	input  logic                     irq_i,
	input  logic                     stomp_i,
	input  logic                     flush_i,
	input  logic                     branchmiss_i,
	input  mux_pkg::pc_t             misspc_i,
	input  mux_pkg::irq_hdr_t        irq_hdr_i,
	output mux_pkg::slot_t           slot_o [`MUX_SLOTS],
	output mux_pkg::irq_hdr_t        irq_hdr_o,
	output logic                     nop_o,
	output logic                     flush_o
);

	// Single-step flag as seen at the last enabled edge
	logic ssm_q;
	logic ssm_first;
	mux_pkg::slot_t slot_d [`MUX_SLOTS];
	logic [`MUX_SLOTS-1:0] vld_q;

	// First cycle of single-step lets exactly one instruction through
	assign ssm_first = ssm_i & ~ssm_q;

	// ====================
	// Slot rules
	// ====================

	always_comb begin
		for (int k = 0; k < `MUX_SLOTS; k++) begin
			slot_d[k].pc = slot_pc_i[k];
			slot_d[k].cli = cli_i[k];
			slot_d[k].ssm = 1'b0;
			// A repeated group carries no work
			slot_d[k].ins = redundant_i ? mux_pkg::NOP_INS : raw_ins_i[k];
			// While stepping only slot 0 of the first cycle survives
			if (ssm_i && (k != 0 || !ssm_first)) begin
				slot_d[k].ins = mux_pkg::NOP_INS;
				slot_d[k].ssm = 1'b1;
			end
			// Interrupt and stomp kill the whole group
			if (k == 0)
				slot_d[k].valid = !(irq_i || stomp_i || (ssm_i && !ssm_first));
			else
				slot_d[k].valid = !(irq_i || stomp_i || ssm_i);
			// Instructions ahead of a mispredicted target must not run
			if (branchmiss_i && (misspc_i > slot_pc_i[k])) begin
				slot_d[k].ins = mux_pkg::NOP_INS;
				slot_d[k].valid = 1'b0;
			end
		end
	end

	// ====================
	// Stage register
	// ====================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ssm_q <= 1'b0;
			nop_o <= 1'b0;
			flush_o <= 1'b0;
			irq_hdr_o.hwi <= 1'b0;
			for (int k = 0; k < `MUX_SLOTS; k++) begin
				slot_o[k].valid <= 1'b0;
				slot_o[k].ssm <= 1'b0;
			end
		end else if (stage_en_i) begin
			ssm_q <= ssm_i;
			nop_o <= stomp_i;
			flush_o <= flush_i;
			// The header marks the group as a hardware interrupt
			irq_hdr_o.hwi <= irq_hdr_i.hwi;
			for (int k = 0; k < `MUX_SLOTS; k++) begin
				slot_o[k].valid <= slot_d[k].valid;
				slot_o[k].ssm <= slot_d[k].ssm;
			end
		end
		// Instruction payload and header details
		if (stage_en_i) begin
			irq_hdr_o.old_ipl <= irq_hdr_i.old_ipl;
			irq_hdr_o.cause <= irq_hdr_i.cause;
			irq_hdr_o.sn <= irq_hdr_i.sn;
			for (int k = 0; k < `MUX_SLOTS; k++) begin
				slot_o[k].cli <= slot_d[k].cli;
				slot_o[k].pc <= slot_d[k].pc;
				slot_o[k].ins <= slot_d[k].ins;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < `MUX_SLOTS; k++)
			vld_q[k] = slot_o[k].valid;
	end

	// An interrupted group never reaches decode with live instructions
	a_hwi_no_valid: assert property (@(posedge clk) disable iff (rst_i)
		irq_hdr_o.hwi |-> (vld_q == '0))
		else $error("valid slot registered together with hwi header");

endmodule

//--- fetch_history.sv
// ====================
// Previous-fetch history
// Flags repeated groups and arrival of a new cache line
// ====================

`timescale 1ns/1ns

`include "mux_settings.svh"

module fetch_history (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      advance_i,
	input  mux_pkg::pc_t              pc_i,
	input  logic [`MUX_WIN_BITS-1:0]  aligned_i,
	input  logic [`MUX_LINE_BITS-1:0] line_i,
	output logic                      redundant_o,
	output logic                      new_cline_o
);

	// PC and window captured at the last advance
	mux_pkg::pc_t prev_pc;
	logic [`MUX_WIN_BITS-1:0] prev_aligned;

	// Two-deep line history, newest in line_q
	logic [`MUX_LINE_BITS-1:0] line_q;
	logic [`MUX_LINE_BITS-1:0] line_qq;

	// ====================
	// History registers
	// ====================

	// Everything here follows the fetch advance only
	// so back-pressure on the mux stage does not disturb it
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc <= '0;
			prev_aligned <= '0;
			line_q <= '0;
			line_qq <= '0;
		end else if (advance_i) begin
			prev_pc <= pc_i;
			prev_aligned <= aligned_i;
			line_qq <= line_q;
			line_q <= line_i;
		end
	end

	// ====================
	// Compare
	// ====================

	// Same PC over the same window means fetch repeated itself
	assign redundant_o = (prev_pc == pc_i) && (prev_aligned == aligned_i);

	// A line differing from the one before it has just entered the stage
	assign new_cline_o = (line_q != line_qq);

endmodule

//--- group_extract.sv
// ====================
// Line alignment and slot cutting
// Builds four raw slots with their PCs and parcel indices
// ====================

`timescale 1ns/1ns

`include "mux_settings.svh"

module group_extract (
	input  logic [`MUX_LINE_BITS-1:0]  line_i,
	input  mux_pkg::pc_t               pc_i,
	output mux_pkg::ins_t              raw_ins_o [`MUX_SLOTS],
	output mux_pkg::pc_t               slot_pc_o [`MUX_SLOTS],
	output logic [`MUX_CLI_BITS-1:0]   cli_o [`MUX_SLOTS],
	output logic [`MUX_WIN_BITS-1:0]   aligned_o
);

	// Number of parcels held by one cache line
	localparam int LINE_PARCELS = `MUX_LINE_BITS / `MUX_PARCEL_BITS;
	localparam int IDX_BITS = $clog2(LINE_PARCELS);

	// Enough NOP parcels above the line to fill a full window
	// when the PC points at the last parcel
	localparam int PAD_PARCELS = `MUX_SLOTS * `MUX_SLOT_STRIDE;
	localparam int PAD_BITS = PAD_PARCELS * `MUX_PARCEL_BITS;
	localparam int EXT_BITS = PAD_BITS + `MUX_LINE_BITS;

	// Byte distance between neighbouring slots
	localparam int SLOT_BYTES = `MUX_SLOT_STRIDE * (`MUX_PARCEL_BITS / 8);

	// A parcel that decodes as NOP
	localparam logic [`MUX_PARCEL_BITS-1:0] NOP_PARCEL =
		{{(`MUX_PARCEL_BITS - 7){1'b0}}, mux_pkg::OP_NOP};

	logic [IDX_BITS-1:0] base_idx;
	logic [EXT_BITS-1:0] padded;
	logic [EXT_BITS-1:0] shifted;

	// ====================
	// Alignment
	// ====================

	// PC bit 0 is a byte within a parcel and is ignored for alignment
	assign base_idx = pc_i[IDX_BITS:1];

	// Parcels past the end of the line read as NOP
	assign padded = {{PAD_PARCELS{NOP_PARCEL}}, line_i};

	// Parcel-granular right shift brings the PC's parcel to bit 0
	assign shifted = padded >> (int'(base_idx) * `MUX_PARCEL_BITS);

	assign aligned_o = shifted[`MUX_WIN_BITS-1:0];

	// ====================
	// Slot cutting
	// ====================

	always_comb begin
		for (int k = 0; k < `MUX_SLOTS; k++) begin
			// Each slot is three parcels of the aligned window
			raw_ins_o[k] = aligned_o[k*`MUX_INS_BITS +: `MUX_INS_BITS];
			// Slot PC steps by six bytes
			slot_pc_o[k] = pc_i + `MUX_PC_BITS'(k * SLOT_BYTES);
			// Parcel index may run past the line end for the upper slots
			cli_o[k] = `MUX_CLI_BITS'(base_idx) + `MUX_CLI_BITS'(k * `MUX_SLOT_STRIDE);
		end
	end

endmodule

//--- mux_pkg.sv
// ====================
// Shared types of the mux stage
// PC, instruction, opcode, slot and interrupt header
// ====================

`include "mux_settings.svh"

package mux_pkg;

	// ====================
	// Scalar types
	// ====================

	// Byte address of an instruction
	typedef logic [`MUX_PC_BITS-1:0] pc_t;

	// Raw instruction as cut from the line
	// Opcode sits in the low seven bits
	typedef logic [`MUX_INS_BITS-1:0] ins_t;

	// Opcodes the front end cares about
	// Everything else decodes as ordinary non-flow work
	typedef enum logic [6:0] {
		OP_NOP = 7'h00,
		OP_ALU = 7'h04,
		OP_BSR = 7'h20,
		OP_JSR = 7'h21,
		OP_RET = 7'h22,
		OP_BCC = 7'h26
	} opcode_e;

	// ====================
	// Composite types
	// ====================

	// One instruction slot of a fetch group
	// The cli field is the parcel index on the cache line
	typedef struct packed {
		logic valid;
		logic ssm;
		logic [`MUX_CLI_BITS-1:0] cli;
		pc_t pc;
		ins_t ins;
	} slot_t;

	// Interrupt header travelling alongside the group
	typedef struct packed {
		logic hwi;
		logic [`MUX_IPL_BITS-1:0] old_ipl;
		logic [7:0] cause;
		logic [7:0] sn;
	} irq_hdr_t;

	// NOP used to fill killed and suppressed slots
	// All operand fields are zero
	localparam ins_t NOP_INS = {{(`MUX_INS_BITS - 7){1'b0}}, OP_NOP};

endpackage

//--- mux_settings.svh
// ====================
// Build-time sizes for the instruction-group mux stage
// Line, parcel, slot and PC widths plus the reset PC
// ====================

`ifndef MUX_SETTINGS_SVH
`define MUX_SETTINGS_SVH

// Cache line delivered by fetch each cycle
`define MUX_LINE_BITS 512

// Smallest addressable instruction unit on the line
`define MUX_PARCEL_BITS 16

// A full instruction is three parcels
`define MUX_INS_BITS 48

// Instructions cut from the line per cycle
`define MUX_SLOTS 4

// Slot k starts k times this many parcels past the PC
`define MUX_SLOT_STRIDE 3

// Byte-address PC width
`define MUX_PC_BITS 32

// Default PC, also the idle value of the flow outputs
`define MUX_RESET_PC 32'hFFFC0000

// Interrupt priority level carried in the header
`define MUX_IPL_BITS 6

// Parcel index of a slot on the line, with headroom past the end
`define MUX_CLI_BITS 6

// Four-slot window handed to the history check
`define MUX_WIN_BITS (`MUX_SLOTS * `MUX_SLOT_STRIDE * `MUX_PARCEL_BITS)

`endif
